//--- Bender.yml
package:
  name: decode_stage

sources:
  - include_dirs:
      - source
    files:
      - source/decodePkg.sv
      - source/decodeAlu.sv
      - source/decodeMem.sv
      - source/decodeBranch.sv
      - source/decodeStage.sv
  - target: simulation
    files:
      - sim/decodeClockGen.sv
      - sim/decodeStage_properties.sv
      - sim/decodeStage_tb.sv

//--- list.f
+incdir+source
source/decodePkg.sv
source/decodeAlu.sv
source/decodeMem.sv
source/decodeBranch.sv
source/decodeStage.sv
sim/decodeClockGen.sv
sim/decodeStage_properties.sv
sim/decodeStage_tb.sv

//--- sim/decodeClockGen.sv
`timescale 1ns/1ps

// Free running clock and power on reset for the decode stage testbench
module decodeClockGen
(
	output logic clk,
	output logic arstN
);

	// Half of the 10 ns period
	localparam realtime HALF_PERIOD = 5ns;

	initial
	begin
		clk = 1'b0;
		forever
			#(HALF_PERIOD) clk = ~clk;
	end

	// Reset spans ten rising edges and is released on a falling edge
	initial
	begin
		arstN = 1'b0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		arstN = 1'b1;
	end

endmodule

//--- sim/decodeStage_properties.sv
`timescale 1ns/1ps

// Structural invariants of the decode output register
module decodeStage_properties
(
	input logic                clk,
	input logic                arstN,
	input logic                stall,
	input decodePkg::decoded_t decoded,
	input logic                outValid
);

	// Count of failed assertions
	int failCount = 0;

	// ==========================================================
	// Class flags
	// ==========================================================

	// An illegal encoding belongs to no unit class at all
	illegalExclusive: assert property (@(posedge clk) disable iff (!arstN)
		decoded.illegal |-> !(decoded.alu | decoded.load | decoded.store |
			decoded.branch | decoded.jump))
		else
		begin
			$error("illegal is set together with a unit class flag");
			failCount++;
		end

	// A single opcode cannot both read and write memory
	loadStoreExclusive: assert property (@(posedge clk) disable iff (!arstN)
		!(decoded.load && decoded.store))
		else
		begin
			$error("load and store are both set");
			failCount++;
		end

	// ==========================================================
	// Register behaviour
	// ==========================================================

	// Stall seen at one edge means that edge left the register alone
	stallHolds: assert property (@(posedge clk) disable iff (!arstN)
		stall |=> ($stable(decoded) && $stable(outValid)))
		else
		begin
			$error("decoded or outValid changed during stall");
			failCount++;
		end

	// Nothing valid leaves the stage while reset is applied
	resetClearsValid: assert property (@(posedge clk)
		!arstN |-> !outValid)
		else
		begin
			$error("outValid is high during reset");
			failCount++;
		end

endmodule

//--- sim/decodeStage_tb.sv
`timescale 1ns/1ps

// Random stimulus for the decode stage, checked against a rule based model
module decodeStage_tb;

	// ==========================================================
	// Run length
	// ==========================================================

	localparam int RUN_CYCLES     = 2000;
	// Reset and the final drain fit easily in the extra half
	localparam int TIMEOUT_CYCLES = RUN_CYCLES + RUN_CYCLES / 2;

	logic                    clk;
	logic                    arstN;
	decodePkg::instruction_t instr;
	logic                    instrValid;
	logic                    stall;
	decodePkg::decoded_t     decoded;
	logic                    outValid;

	// Model state, updated on every edge that is not stalled
	decodePkg::decoded_t     expDecoded;
	logic                    expValid;

	int seed;
	int cycleCount;
	int aluErrors;
	int memErrors;
	int flowErrors;
	int regErrors;
	int timingErrors;
	int resetErrors;

	// Defined opcodes and function codes that the generator mostly picks from
	decodePkg::opcode_t opList [0:23] = '{decodePkg::OP_R2, decodePkg::OP_FLT,
		decodePkg::OP_ADDI, decodePkg::OP_SUBFI, decodePkg::OP_CMPI, decodePkg::OP_MULI,
		decodePkg::OP_DIVI, decodePkg::OP_ANDI, decodePkg::OP_ORI, decodePkg::OP_EORI,
		decodePkg::OP_SHIFT, decodePkg::OP_SLTI, decodePkg::OP_SLTUI, decodePkg::OP_MOV,
		decodePkg::OP_CSR, decodePkg::OP_NOP, decodePkg::OP_LOAD, decodePkg::OP_LOADU,
		decodePkg::OP_STORE, decodePkg::OP_BCC, decodePkg::OP_BCCU, decodePkg::OP_BSR,
		decodePkg::OP_JSR, decodePkg::OP_RTD};
	decodePkg::func_t fnList [0:18] = '{decodePkg::FN_ADD, decodePkg::FN_SUB,
		decodePkg::FN_CMP, decodePkg::FN_MUL, decodePkg::FN_DIV, decodePkg::FN_AND,
		decodePkg::FN_OR, decodePkg::FN_EOR, decodePkg::FN_NAND, decodePkg::FN_NOR,
		decodePkg::FN_SLT, decodePkg::FN_SLTU, decodePkg::FN_SEQ, decodePkg::FN_SNE,
		decodePkg::FN_FABS, decodePkg::FN_FNEG, decodePkg::FN_FCMP, decodePkg::FN_FADD,
		decodePkg::FN_FMUL};

	decodeClockGen clockGen
	(
		.clk   (clk),
		.arstN (arstN)
	);

	decodeStage i_dut
	(
		.clk        (clk),
		.arstN      (arstN),
		.instr      (instr),
		.instrValid (instrValid),
		.stall      (stall),
		.decoded    (decoded),
		.outValid   (outValid)
	);

	bind decodeStage decodeStage_properties props
	(
		.clk      (clk),
		.arstN    (arstN),
		.stall    (stall),
		.decoded  (decoded),
		.outValid (outValid)
	);

	// ==========================================================
	// Reference model
	// ==========================================================

	// Expected result written straight from the decode rules
	function automatic decodePkg::decoded_t expectDecode(input decodePkg::instruction_t ir);
		decodePkg::decoded_t d;
		logic [6:0] op;
		logic [6:0] fn;
		logic r2Fn;
		logic fltFn;
		op    = ir.opcode;
		fn    = ir.func;
		r2Fn  = fn inside {decodePkg::FN_ADD, decodePkg::FN_SUB, decodePkg::FN_CMP,
			decodePkg::FN_MUL, decodePkg::FN_DIV, decodePkg::FN_AND, decodePkg::FN_OR,
			decodePkg::FN_EOR, decodePkg::FN_NAND, decodePkg::FN_NOR, decodePkg::FN_SLT,
			decodePkg::FN_SLTU, decodePkg::FN_SEQ, decodePkg::FN_SNE};
		fltFn = fn inside {decodePkg::FN_FABS, decodePkg::FN_FNEG, decodePkg::FN_FCMP};
		d = '0;
		d.branch = op inside {decodePkg::OP_BCC, decodePkg::OP_BCCU};
		d.jump   = op inside {decodePkg::OP_BSR, decodePkg::OP_JSR, decodePkg::OP_RTD};
		d.alu    = (op == decodePkg::OP_R2 && r2Fn) || (op == decodePkg::OP_FLT && fltFn)
			|| d.jump || (d.branch && ir.inc != 0)
			|| op inside {decodePkg::OP_ADDI, decodePkg::OP_SUBFI, decodePkg::OP_CMPI,
				decodePkg::OP_MULI, decodePkg::OP_DIVI, decodePkg::OP_ANDI, decodePkg::OP_ORI,
				decodePkg::OP_EORI, decodePkg::OP_SHIFT, decodePkg::OP_SLTI,
				decodePkg::OP_SLTUI, decodePkg::OP_MOV, decodePkg::OP_CSR, decodePkg::OP_NOP};
		d.load        = op inside {decodePkg::OP_LOAD, decodePkg::OP_LOADU};
		d.memUnsigned = (op == decodePkg::OP_LOADU);
		d.store       = (op == decodePkg::OP_STORE);
		// Size only means something on memory opcodes
		if (d.load || d.store)
			d.memSize = decodePkg::memSize_t'(fn[1:0]);
		else
			d.memSize = decodePkg::SZ_BYTE;
		d.illegal  = !(d.alu || d.load || d.store || d.branch || d.jump);
		d.writesRd = (d.alu || d.load || d.jump) && !d.branch && (ir.rd != 0);
		d.rd  = ir.rd;
		d.rs1 = ir.rs1;
		d.rs2 = ir.rs2;
		return d;
	endfunction

	// ==========================================================
	// Stimulus and checks
	// ==========================================================

	task automatic reportMismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("error at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
	endtask

	// Mostly legal encodings, with a few unused opcodes and function codes
	task automatic driveRandom;
		logic [31:0] rnd;
		rnd = $random(seed);
		if (rnd % 8 == 0)
			instr.opcode = decodePkg::opcode_t'(rnd[14:8]);
		else
			instr.opcode = opList[(rnd >> 8) % 24];
		rnd = $random(seed);
		if (rnd % 6 == 0)
			instr.func = rnd[14:8];
		else
			instr.func = fnList[(rnd >> 8) % 19];
		rnd = $random(seed);
		instr.rd  = rnd[4:0];
		instr.rs1 = rnd[9:5];
		instr.rs2 = rnd[14:10];
		// Half of the branches carry no increment
		instr.inc = rnd[15] ? 3'd0 : rnd[18:16];
		rnd = $random(seed);
		instrValid = (rnd % 100) < 80;
		rnd = $random(seed);
		stall = (rnd % 100) < 15;
	endtask

	task automatic checkResetState;
		if (outValid !== 1'b0)
		begin
			reportMismatch("outValid", 32'd0, outValid);
			resetErrors++;
		end
		if (decoded !== '0)
		begin
			reportMismatch("decoded", 32'd0, decoded);
			resetErrors++;
		end
	endtask

	task automatic compareOutputs;
		if (outValid !== expValid)
		begin
			reportMismatch("outValid", expValid, outValid);
			timingErrors++;
		end
		// The register contents only matter while the output is valid
		if (expValid)
		begin
			if (decoded.alu !== expDecoded.alu)
			begin
				reportMismatch("decoded.alu", expDecoded.alu, decoded.alu);
				aluErrors++;
			end
			if ({decoded.load, decoded.store, decoded.memUnsigned, decoded.memSize} !==
				{expDecoded.load, expDecoded.store, expDecoded.memUnsigned, expDecoded.memSize})
			begin
				reportMismatch("load/store/memUnsigned/memSize",
					{expDecoded.load, expDecoded.store, expDecoded.memUnsigned, expDecoded.memSize},
					{decoded.load, decoded.store, decoded.memUnsigned, decoded.memSize});
				memErrors++;
			end
			if ({decoded.branch, decoded.jump, decoded.illegal} !==
				{expDecoded.branch, expDecoded.jump, expDecoded.illegal})
			begin
				reportMismatch("branch/jump/illegal",
					{expDecoded.branch, expDecoded.jump, expDecoded.illegal},
					{decoded.branch, decoded.jump, decoded.illegal});
				flowErrors++;
			end
			if ({decoded.writesRd, decoded.rd, decoded.rs1, decoded.rs2} !==
				{expDecoded.writesRd, expDecoded.rd, expDecoded.rs1, expDecoded.rs2})
			begin
				reportMismatch("writesRd/rd/rs1/rs2",
					{expDecoded.writesRd, expDecoded.rd, expDecoded.rs1, expDecoded.rs2},
					{decoded.writesRd, decoded.rd, decoded.rs1, decoded.rs2});
				regErrors++;
			end
		end
	endtask

	// Hard stop in case the DUT or the testbench loop stops making progress
	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount >= TIMEOUT_CYCLES)
		begin
			$display("Timeout after %0d cycles, the run did not complete", cycleCount);
			$display("Errors found");
			$finish;
		end
	end

	initial
	begin
		int total;
		seed         = 72628;
		cycleCount   = 0;
		aluErrors    = 0;
		memErrors    = 0;
		flowErrors   = 0;
		regErrors    = 0;
		timingErrors = 0;
		resetErrors  = 0;
		// Stall stays high past reset so the first edge after release changes nothing
		instr        = '0;
		instrValid   = 1'b0;
		stall        = 1'b1;
		expDecoded   = '0;
		expValid     = 1'b0;

		@(posedge clk);
		while (arstN !== 1'b1)
		begin
			#1;
			checkResetState();
			@(posedge clk);
		end
		#1;
		checkResetState();
		driveRandom();

		// Model samples the same inputs the DUT sees, outputs are read 1 ns later
		for (int cycle = 0; cycle < RUN_CYCLES; cycle++)
		begin
			@(posedge clk);
			if (!stall)
			begin
				expDecoded = expectDecode(instr);
				expValid   = instrValid;
			end
			#1;
			compareOutputs();
			driveRandom();
		end

		total = aluErrors + memErrors + flowErrors + regErrors + timingErrors + resetErrors
			+ i_dut.props.failCount;
		$display({"Error counts: alu %0d, mem %0d, flow %0d, reg %0d, timing %0d, ",
			"reset %0d, assert %0d"}, aluErrors, memErrors, flowErrors, regErrors,
			timingErrors, resetErrors, i_dut.props.failCount);
		if (total == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

//--- source/decodeAlu.sv
`timescale 1ns/1ps

// Flags instructions that need a slot on the integer ALU
module decodeAlu
(
	input  decodePkg::instruction_t instr,
	output logic                    alu
);

	// Walks the opcode first and only looks at func where the opcode is shared
	function automatic logic fnIsAlu(input decodePkg::instruction_t ir);
		logic isAlu;
		isAlu = 1'b0;
		case (ir.opcode)
			// ==========================================================
			// Register to register forms
			// ==========================================================
			decodePkg::OP_R2:
				case (ir.func)
					decodePkg::FN_ADD:  isAlu = 1'b1;
					decodePkg::FN_SUB:  isAlu = 1'b1;
					decodePkg::FN_CMP:  isAlu = 1'b1;
					decodePkg::FN_MUL:  isAlu = 1'b1;
					decodePkg::FN_DIV:  isAlu = 1'b1;
					decodePkg::FN_AND:  isAlu = 1'b1;
					decodePkg::FN_OR:   isAlu = 1'b1;
					decodePkg::FN_EOR:  isAlu = 1'b1;
					decodePkg::FN_NAND: isAlu = 1'b1;
					decodePkg::FN_NOR:  isAlu = 1'b1;
					decodePkg::FN_SLT:  isAlu = 1'b1;
					decodePkg::FN_SLTU: isAlu = 1'b1;
					decodePkg::FN_SEQ:  isAlu = 1'b1;
					decodePkg::FN_SNE:  isAlu = 1'b1;
					// Any other function under R2 is not implemented
					default:            isAlu = 1'b0;
				endcase
			// Sign manipulation and compare are plain bit operations
			// The arithmetic float functions have no unit here
			decodePkg::OP_FLT:
				case (ir.func)
					decodePkg::FN_FABS: isAlu = 1'b1;
					decodePkg::FN_FNEG: isAlu = 1'b1;
					decodePkg::FN_FCMP: isAlu = 1'b1;
					default:            isAlu = 1'b0;
				endcase
			// ==========================================================
			// Immediate forms and miscellaneous
			// ==========================================================
			decodePkg::OP_ADDI:  isAlu = 1'b1;
			decodePkg::OP_SUBFI: isAlu = 1'b1;
			decodePkg::OP_CMPI:  isAlu = 1'b1;
			decodePkg::OP_MULI:  isAlu = 1'b1;
			decodePkg::OP_DIVI:  isAlu = 1'b1;
			decodePkg::OP_ANDI:  isAlu = 1'b1;
			decodePkg::OP_ORI:   isAlu = 1'b1;
			decodePkg::OP_EORI:  isAlu = 1'b1;
			decodePkg::OP_SHIFT: isAlu = 1'b1;
			decodePkg::OP_SLTI:  isAlu = 1'b1;
			decodePkg::OP_SLTUI: isAlu = 1'b1;
			decodePkg::OP_MOV:   isAlu = 1'b1;
			decodePkg::OP_CSR:   isAlu = 1'b1;
			// A NOP still occupies an ALU slot so it retires in order
			decodePkg::OP_NOP:   isAlu = 1'b1;
			// ==========================================================
			// Control flow that also produces a result
			// ==========================================================
			// Calls write the link register
			decodePkg::OP_BSR,
			decodePkg::OP_JSR:
				isAlu = 1'b1;
			// The return adjusts the stack pointer on the way out
			decodePkg::OP_RTD:
				isAlu = 1'b1;
			// A branch with a nonzero increment also bumps a loop register
			decodePkg::OP_BCC,
			decodePkg::OP_BCCU:
				isAlu = |ir.inc;
			// Memory and unused opcodes never go to the ALU
			default:
				isAlu = 1'b0;
		endcase
		return isAlu;
	endfunction

	assign alu = fnIsAlu(instr);

endmodule

//--- source/decodeBranch.sv
`timescale 1ns/1ps

// Splits control flow into conditional branches and unconditional transfers
module decodeBranch
(
	input  decodePkg::instruction_t instr,
	output logic                    branch,
	output logic                    jump
);

	always_comb
	begin
		branch = 1'b0;
		jump   = 1'b0;
		case (instr.opcode)
			// ==========================================================
			// Conditional
			// ==========================================================
			// The compare is signed for BCC and unsigned for BCCU
			// Both resolve later in the branch unit
			decodePkg::OP_BCC,
			decodePkg::OP_BCCU:
				branch = 1'b1;
			// ==========================================================
			// Unconditional
			// ==========================================================
			// Relative and register indirect calls
			decodePkg::OP_BSR,
			decodePkg::OP_JSR:
				jump = 1'b1;
			// Return counts as a jump because the target is always taken
			decodePkg::OP_RTD:
				jump = 1'b1;
			// Nothing else redirects the fetch stream
			default:
			begin
				branch = 1'b0;
				jump   = 1'b0;
			end
		endcase
	end

endmodule

//--- source/decodeMem.sv
`timescale 1ns/1ps

// Recognizes loads and stores and pulls out the access attributes
module decodeMem
(
	input  decodePkg::instruction_t instr,
	output logic                    load,
	output logic                    store,
	output logic                    memUnsigned,
	output decodePkg::memSize_t     memSize
);

	// Set for any of the three memory opcodes
	logic isMem;

	always_comb
	begin
		load        = 1'b0;
		store       = 1'b0;
		memUnsigned = 1'b0;
		case (instr.opcode)
			decodePkg::OP_LOAD:
				load = 1'b1;
			// Same as a load except the value is zero extended
			decodePkg::OP_LOADU:
			begin
				load        = 1'b1;
				memUnsigned = 1'b1;
			end
			decodePkg::OP_STORE:
				store = 1'b1;
			default:
			begin
				load        = 1'b0;
				store       = 1'b0;
				memUnsigned = 1'b0;
			end
		endcase
	end

	assign isMem = load | store;

	// The low two bits of func carry the size on memory opcodes
	// Everything else reports byte so the output register never sees junk
	assign memSize = isMem ? decodePkg::memSize_t'(instr.func[1:0]) : decodePkg::SZ_BYTE;

endmodule

//--- source/decodePkg.sv
`include "decode_defines.svh"

package decodePkg;

	// ==========================================================
	// Major opcodes
	// ==========================================================

	// Codes missing from this list are unused and decode as illegal
	typedef enum logic [`OPCODE_WIDTH-1:0]
	{
		// Register and immediate arithmetic
		OP_R2     = 7'd2,
		OP_FLT    = 7'd3,
		OP_ADDI   = 7'd4,
		OP_SUBFI  = 7'd5,
		OP_CMPI   = 7'd6,
		OP_MULI   = 7'd7,
		OP_DIVI   = 7'd8,
		OP_ANDI   = 7'd9,
		OP_ORI    = 7'd10,
		OP_EORI   = 7'd11,
		OP_SHIFT  = 7'd12,
		OP_SLTI   = 7'd13,
		OP_SLTUI  = 7'd14,
		OP_MOV    = 7'd15,
		OP_CSR    = 7'd16,
		// Subroutine calls and returns
		OP_BSR    = 7'd32,
		OP_JSR    = 7'd33,
		OP_RTD    = 7'd34,
		// Conditional branches, signed and unsigned compare
		OP_BCC    = 7'd40,
		OP_BCCU   = 7'd41,
		// Loads and stores
		OP_LOAD   = 7'd64,
		OP_LOADU  = 7'd65,
		OP_STORE  = 7'd72,
		// The all ones code is a no-operation
		OP_NOP    = 7'd127
	} opcode_t;

	// ==========================================================
	// Function codes
	// ==========================================================

	// R2 functions are in the lower half and FLT functions start at 32
	typedef enum logic [`FUNC_WIDTH-1:0]
	{
		FN_ADD    = 7'd4,
		FN_SUB    = 7'd5,
		FN_CMP    = 7'd6,
		FN_MUL    = 7'd8,
		FN_DIV    = 7'd9,
		FN_AND    = 7'd12,
		FN_OR     = 7'd13,
		FN_EOR    = 7'd14,
		FN_NAND   = 7'd16,
		FN_NOR    = 7'd17,
		FN_SLT    = 7'd24,
		FN_SLTU   = 7'd25,
		FN_SEQ    = 7'd26,
		FN_SNE    = 7'd27,
		// Only FABS, FNEG and FCMP are handled by the integer ALU
		FN_FABS   = 7'd32,
		FN_FNEG   = 7'd33,
		FN_FCMP   = 7'd34,
		FN_FADD   = 7'd35,
		FN_FMUL   = 7'd36
	} func_t;

	// Access size taken from the low two bits of func on memory opcodes
	typedef enum logic [1:0]
	{
		SZ_BYTE   = 2'd0,
		SZ_WYDE   = 2'd1,
		SZ_TETRA  = 2'd2,
		SZ_OCTA   = 2'd3
	} memSize_t;

	// ==========================================================
	// Instruction and decode result
	// ==========================================================

	// Fields are listed from the most significant bit down
	typedef struct packed
	{
		logic [`INC_WIDTH-1:0]  inc;
		logic [`FUNC_WIDTH-1:0] func;
		logic [`REG_WIDTH-1:0]  rs2;
		logic [`REG_WIDTH-1:0]  rs1;
		logic [`REG_WIDTH-1:0]  rd;
		opcode_t                opcode;
	} instruction_t;

	// Everything the later stages need from one instruction
	typedef struct packed
	{
		logic                   alu;
		logic                   load;
		logic                   store;
		logic                   memUnsigned;
		memSize_t               memSize;
		logic                   branch;
		logic                   jump;
		logic                   illegal;
		logic                   writesRd;
		logic [`REG_WIDTH-1:0]  rd;
		logic [`REG_WIDTH-1:0]  rs1;
		logic [`REG_WIDTH-1:0]  rs2;
	} decoded_t;

endpackage

//--- source/decodeStage.sv
`timescale 1ns/1ps

// Instruction decode stage with a single output register
module decodeStage
(
	input  logic                    clk,
	input  logic                    arstN,
	input  decodePkg::instruction_t instr,
	input  logic                    instrValid,
	input  logic                    stall,
	output decodePkg::decoded_t     decoded,
	output logic                    outValid
);

	// ==========================================================
	// Classifier outputs
	// ==========================================================

	logic                isAlu;
	logic                isLoad;
	logic                isStore;
	logic                isUnsigned;
	decodePkg::memSize_t sizeSel;
	logic                isBranch;
	logic                isJump;

	// Result for the instruction on the input this cycle
	decodePkg::decoded_t nextDecoded;

	// The three classifiers look at the same word in parallel
	decodeAlu aluDec
	(
		.instr (instr),
		.alu   (isAlu)
	);

	decodeMem memDec
	(
		.instr       (instr),
		.load        (isLoad),
		.store       (isStore),
		.memUnsigned (isUnsigned),
		.memSize     (sizeSel)
	);

	decodeBranch branchDec
	(
		.instr  (instr),
		.branch (isBranch),
		.jump   (isJump)
	);

	// ==========================================================
	// Combine into one result
	// ==========================================================

	always_comb
	begin
		nextDecoded.alu         = isAlu;
		nextDecoded.load        = isLoad;
		nextDecoded.store       = isStore;
		nextDecoded.memUnsigned = isUnsigned;
		nextDecoded.memSize     = sizeSel;
		nextDecoded.branch      = isBranch;
		nextDecoded.jump        = isJump;
		// An encoding that no classifier claims cannot be executed
		nextDecoded.illegal     = ~(isAlu | isLoad | isStore | isBranch | isJump);
		// Conditional branches only update the loop register through inc
		// so they never target rd
		// Register zero is hardwired and never counts as a destination
		nextDecoded.writesRd    = (isAlu | isLoad | isJump) & ~isBranch & (|instr.rd);
		// Register specifiers go through untouched for the register read stage
		nextDecoded.rd          = instr.rd;
		nextDecoded.rs1         = instr.rs1;
		nextDecoded.rs2         = instr.rs2;
	end

	// ==========================================================
	// Output register
	// ==========================================================

	// Stall freezes the whole register and drops whatever is on the input
	// Without stall the valid level simply follows the input strobe
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			decoded  <= '0;
			outValid <= 1'b0;
		end
		else if (!stall)
		begin
			decoded  <= nextDecoded;
			outValid <= instrValid;
		end
	end

endmodule

//--- source/decode_defines.svh
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

// ==========================================================
// Instruction geometry
// ==========================================================

// Every instruction word is 32 bits wide
`define INSTR_WIDTH 32

// The major opcode occupies the least significant bits
`define OPCODE_WIDTH 7

// Function code that selects the operation under R2 and FLT
`define FUNC_WIDTH 7

// Each register specifier addresses one of 32 registers
`define REG_WIDTH 5

// The branch increment takes the bits left over at the top of the word
// With the widths above this works out to three bits
`define INC_WIDTH (`INSTR_WIDTH - `FUNC_WIDTH - 3 * `REG_WIDTH - `OPCODE_WIDTH)

`endif
